// File: Makefile
TOP = operand_read_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "simulation did not complete"; exit 1; fi

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: project.f
+incdir+src
src/rvfwd_pkg.sv
src/reg_file.sv
src/operand_forward.sv
src/operand_stage.sv
src/operand_read_top.sv
testbench/operand_read_properties.sv
testbench/operand_read_tb.sv

// File: src/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvfwd_defines.svh"

module operand_forward (
    input  wire rvfwd_pkg::src_req_t req,
    input  wire rvfwd_pkg::ex_fwd_t  ex_fwd,
    input  wire rvfwd_pkg::fwd_src_t mem_fwd,
    input  wire rvfwd_pkg::fwd_src_t wb_fwd,
    input  wire rvfwd_pkg::xword_t   rf_rs1,
    input  wire rvfwd_pkg::xword_t   rf_rs2,
    output rvfwd_pkg::operand_pair_t fwd_ops
);

    import rvfwd_pkg::*;

    xword_view_u ex_raw;
    xword_t      ex_data;

    logic rs1_zero;
    logic rs2_zero;
    logic rs1_ex_hit;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;

    xword_t op1;
    xword_t op2;

    // a pending write hits when it is valid and targets the source
    function automatic logic stage_hit(
        input fwd_src_t  stage,
        input reg_addr_t rs
    );
        return stage.valid && (stage.rd == rs);
    endfunction

    assign ex_raw.dword = ex_fwd.src.data;

    // size extension of the execute result, done once for both operands
    always_comb begin
        unique case (ex_fwd.ext)
            EXT_NONE: begin
                ex_data = {ex_raw.lanes.hi, ex_raw.lanes.lo};
            end
            EXT_SEXTW: begin
                ex_data = {{(`XLEN-`HALF_XLEN){ex_raw.lanes.lo[`HALF_XLEN-1]}},
                           ex_raw.lanes.lo};
            end
            EXT_ZEXTW: begin
                ex_data = {{(`XLEN-`HALF_XLEN){1'b0}}, ex_raw.lanes.lo};
            end
            EXT_SEXTH: begin
                ex_data = {{(`XLEN-`HALF_WIDTH){ex_raw.lanes.lo[`HALF_WIDTH-1]}},
                           ex_raw.lanes.lo[`HALF_WIDTH-1:0]};
            end
            EXT_SEXTB: begin
                ex_data = {{(`XLEN-`BYTE_WIDTH){ex_raw.lanes.lo[`BYTE_WIDTH-1]}},
                           ex_raw.lanes.lo[`BYTE_WIDTH-1:0]};
            end
            default: begin
                ex_data = ex_raw.dword;  // unknown code, pass through
            end
        endcase
    end

    assign rs1_zero    = (req.rs1 == '0);
    assign rs2_zero    = (req.rs2 == '0);

    assign rs1_ex_hit  = stage_hit(ex_fwd.src, req.rs1);
    assign rs1_mem_hit = stage_hit(mem_fwd, req.rs1);
    assign rs1_wb_hit  = stage_hit(wb_fwd, req.rs1);

    assign rs2_ex_hit  = stage_hit(ex_fwd.src, req.rs2);
    assign rs2_mem_hit = stage_hit(mem_fwd, req.rs2);
    assign rs2_wb_hit  = stage_hit(wb_fwd, req.rs2);

    // youngest producer wins
    always_comb begin
        if (rs1_zero) begin
            op1 = '0;  // x0 never forwarded
        end else if (rs1_ex_hit) begin
            op1 = ex_data;
        end else if (rs1_mem_hit) begin
            op1 = mem_fwd.data;
        end else if (rs1_wb_hit) begin
            op1 = wb_fwd.data;  // rf write not landed yet
        end else begin
            op1 = rf_rs1;
        end
    end

    always_comb begin
        if (rs2_zero) begin
            op2 = '0;
        end else if (rs2_ex_hit) begin
            op2 = ex_data;
        end else if (rs2_mem_hit) begin
            op2 = mem_fwd.data;
        end else if (rs2_wb_hit) begin
            op2 = wb_fwd.data;
        end else begin
            op2 = rf_rs2;
        end
    end

    assign fwd_ops.valid = req.strobe;
    assign fwd_ops.op1   = op1;
    assign fwd_ops.op2   = op2;

endmodule

`default_nettype wire

// File: src/operand_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire rvfwd_pkg::src_req_t req,
    input  wire rvfwd_pkg::ex_fwd_t  ex_fwd,
    input  wire rvfwd_pkg::fwd_src_t mem_fwd,
    input  wire rvfwd_pkg::fwd_src_t wb_fwd,
    output rvfwd_pkg::operand_pair_t operands
);

    import rvfwd_pkg::*;

    xword_t        rf_rs1;
    xword_t        rf_rs2;
    operand_pair_t fwd_ops;

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (req.rs1),
        .rs2    (req.rs2),
        .wb_fwd (wb_fwd),
        .rf_rs1 (rf_rs1),
        .rf_rs2 (rf_rs2)
    );

    operand_forward operand_forward_i (
        .req     (req),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .rf_rs1  (rf_rs1),
        .rf_rs2  (rf_rs2),
        .fwd_ops (fwd_ops)
    );

    operand_stage operand_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .fwd_ops  (fwd_ops),
        .operands (operands)
    );

endmodule

`default_nettype wire

// File: src/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire rvfwd_pkg::operand_pair_t fwd_ops,
    output rvfwd_pkg::operand_pair_t operands
);

    import rvfwd_pkg::*;

    logic   valid_q;
    xword_t op1_q;
    xword_t op2_q;

    // valid follows the strobe every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fwd_ops.valid;
        end
    end

    // data only moves on a request, holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_q <= '0;
            op2_q <= '0;
        end else if (fwd_ops.valid) begin
            op1_q <= fwd_ops.op1;
            op2_q <= fwd_ops.op2;
        end
    end

    assign operands.valid = valid_q;
    assign operands.op1   = op1_q;
    assign operands.op2   = op2_q;

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvfwd_defines.svh"

module reg_file (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rvfwd_pkg::reg_addr_t rs1,
    input  wire rvfwd_pkg::reg_addr_t rs2,
    input  wire rvfwd_pkg::fwd_src_t  wb_fwd,
    output rvfwd_pkg::xword_t    rf_rs1,
    output rvfwd_pkg::xword_t    rf_rs2
);

    import rvfwd_pkg::*;

    xword_t regs [`REG_COUNT];
    logic   wr_en;

    // x0 is hardwired, so drop writes to it
    assign wr_en = wb_fwd.valid && (wb_fwd.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_fwd.rd] <= wb_fwd.data;
        end
    end

    // combinational read, new data visible the cycle after the write edge
    assign rf_rs1 = regs[rs1];
    assign rf_rs2 = regs[rs2];

endmodule

`default_nettype wire

// File: src/rvfwd_defines.svh
`ifndef RVFWD_DEFINES_SVH
`define RVFWD_DEFINES_SVH

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32

// datapath widths, RV64 only
`define XLEN           64
`define HALF_XLEN      32
`define HALF_WIDTH     16
`define BYTE_WIDTH     8

// execute result extension codes
`define EXT_KIND_WIDTH 3
`define EXT_CODE_NONE  3'd0
`define EXT_CODE_SEXTW 3'd1
`define EXT_CODE_ZEXTW 3'd2
`define EXT_CODE_SEXTH 3'd3
`define EXT_CODE_SEXTB 3'd4

`endif

// File: src/rvfwd_pkg.sv
`default_nettype none
`include "rvfwd_defines.svh"

package rvfwd_pkg;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`XLEN-1:0]           xword_t;

    typedef enum logic [`EXT_KIND_WIDTH-1:0] {
        EXT_NONE  = `EXT_CODE_NONE,   // full dword
        EXT_SEXTW = `EXT_CODE_SEXTW,  // lw, addw and friends
        EXT_ZEXTW = `EXT_CODE_ZEXTW,  // lwu
        EXT_SEXTH = `EXT_CODE_SEXTH,  // lh
        EXT_SEXTB = `EXT_CODE_SEXTB   // lb
    } ext_kind_e;

    typedef struct packed {
        logic [`HALF_XLEN-1:0] hi;
        logic [`HALF_XLEN-1:0] lo;
    } word_lanes_t;

    // one result, seen whole or as two word lanes
    typedef union packed {
        xword_t      dword;
        word_lanes_t lanes;
    } xword_view_u;

    typedef struct packed {
        logic      strobe;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } src_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xword_t    data;
    } fwd_src_t;

    typedef struct packed {
        fwd_src_t  src;
        ext_kind_e ext;
    } ex_fwd_t;

    typedef struct packed {
        logic   valid;
        xword_t op1;
        xword_t op2;
    } operand_pair_t;

endpackage

`default_nettype wire

// File: testbench/operand_patterns.txt
# strobe rs1 rs2 | ex valid rd ext data | mem valid rd data | wb valid rd data | exp op1 op2
# all hex, ext 0 none 1 sext word 2 zext word 3 sext half 4 sext byte
0 00 00 0 00 0 0 0 00 0 1 01 1111 0 0
0 00 00 0 00 0 0 0 00 0 1 02 2222 0 0
0 00 00 0 00 0 0 0 00 0 1 03 8000000000000033 0 0
0 00 00 0 00 0 0 0 00 0 1 00 dead 0 0
1 01 02 0 00 0 0 0 00 0 0 00 0 1111 2222
1 00 03 0 00 0 0 0 00 0 0 00 0 0 8000000000000033
1 03 01 0 00 0 0 0 00 0 0 00 0 8000000000000033 1111
1 01 02 1 01 0 aaaa 1 01 bbbb 1 01 cccc aaaa 2222
1 01 02 1 02 0 5555 1 02 6666 0 00 0 cccc 5555
1 03 03 1 03 0 77 1 03 88 1 03 99 77 77
1 04 00 1 04 1 1234567880000001 0 00 0 0 00 0 ffffffff80000001 0
1 04 00 1 04 1 123456787fff0000 0 00 0 0 00 0 7fff0000 0
1 04 04 1 04 2 ffffffff80000001 0 00 0 0 00 0 80000001 80000001
1 04 00 1 04 3 123456789abc8001 1 04 4444 0 00 0 ffffffffffff8001 0
1 04 00 1 04 3 123456789abc7001 0 00 0 0 00 0 7001 0
1 00 04 1 04 4 123456789abcde80 0 00 0 0 00 0 0 ffffffffffffff80
1 00 04 1 04 4 123456789abcde7f 0 00 0 0 00 0 0 7f
1 04 04 1 04 0 fedcba9876543210 0 00 0 0 00 0 fedcba9876543210 fedcba9876543210
1 05 02 0 00 0 0 1 05 5050 1 05 6060 5050 2222
1 06 05 0 00 0 0 0 00 0 1 06 6666 6666 6060
1 06 01 0 00 0 0 0 00 0 0 00 0 6666 cccc
1 02 03 1 02 0 2e2e 1 03 3d3d 0 00 0 2e2e 3d3d
1 01 06 1 07 0 7777 1 01 1d1d 1 06 6f6f 1d1d 6f6f
1 03 05 1 05 4 81 0 00 0 0 00 0 99 ffffffffffffff81
0 03 05 1 03 0 abab 1 05 cdcd 1 08 8888 99 ffffffffffffff81
1 08 06 0 00 0 0 0 00 0 0 00 0 8888 6f6f
1 00 00 1 00 0 ffff 1 00 eeee 1 00 dddd 0 0
1 02 01 0 02 0 dead 0 01 beef 0 00 0 2222 cccc
0 00 00 0 00 0 0 0 00 0 0 00 0 2222 cccc

// File: testbench/operand_read_properties.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read_properties (
    input wire                           clk,
    input wire                           rst_n,
    input wire rvfwd_pkg::src_req_t      req,
    input wire rvfwd_pkg::operand_pair_t operands
);

    int unsigned fail_count = 0;  // read by the testbench

    // quiet while in reset
    assert property (@(posedge clk) !rst_n |-> !operands.valid)
        else begin
            $error("operands.valid high during reset");
            fail_count++;
        end

    assert property (@(posedge clk) $past(!rst_n) && rst_n |-> !operands.valid)
        else begin
            $error("operands.valid high in the first cycle after reset");
            fail_count++;
        end

    // one pulse per strobe after one cycle
    assert property (@(posedge clk) disable iff (!rst_n)
                     $past(rst_n) |-> operands.valid == $past(req.strobe))
        else begin
            $error("operands.valid does not follow the strobe");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     operands.valid && ($past(req.rs1) == '0) |-> operands.op1 == '0)
        else begin
            $error("op1 nonzero for source x0");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     operands.valid && ($past(req.rs2) == '0) |-> operands.op2 == '0)
        else begin
            $error("op2 nonzero for source x0");
            fail_count++;
        end

endmodule

bind operand_read_top operand_read_properties operand_read_properties_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands)
);

`default_nettype wire

// File: testbench/operand_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read_tb;

    import rvfwd_pkg::*;

    logic          clk;
    logic          rst_n;
    src_req_t      req;
    ex_fwd_t       ex_fwd;
    fwd_src_t      mem_fwd;
    fwd_src_t      wb_fwd;
    operand_pair_t operands;

    src_req_t      req_q[$];
    ex_fwd_t       ex_q[$];
    fwd_src_t      mem_q[$];
    fwd_src_t      wb_q[$];
    operand_pair_t exp_q[$];
    int            num_vectors;
    bit            vectors_loaded;

    operand_read_top operand_read_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .operands (operands)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_valid(input operand_pair_t got, input operand_pair_t exp, input int idx);
        if (got.valid !== exp.valid) begin
            abort_run($sformatf("Fail operands.valid vector %0d: got %h expected %h",
                                idx, got.valid, exp.valid));
        end
    endtask

    task automatic check_operands(input operand_pair_t got, input operand_pair_t exp,
                                  input int idx);
        if (got.op1 !== exp.op1) begin
            abort_run($sformatf("Fail operands.op1 vector %0d: got %h expected %h",
                                idx, got.op1, exp.op1));
        end else if (got.op2 !== exp.op2) begin
            abort_run($sformatf("Fail operands.op2 vector %0d: got %h expected %h",
                                idx, got.op2, exp.op2));
        end
    endtask

    // count comes back -1 when the file cannot be opened
    task automatic load_patterns(output int count);
        int            fd;
        int            fields;
        string         line;
        logic [63:0]   f [0:14];
        src_req_t      r;
        ex_fwd_t       e;
        fwd_src_t      m;
        fwd_src_t      w;
        operand_pair_t x;
        count = 0;
        fd = $fopen("testbench/operand_patterns.txt", "r");
        if (fd == 0) begin
            count = -1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip header and blanks
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                     f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (fields == 15) begin
                        r.strobe    = f[0][0];
                        r.rs1       = reg_addr_t'(f[1]);
                        r.rs2       = reg_addr_t'(f[2]);
                        e.src.valid = f[3][0];
                        e.src.rd    = reg_addr_t'(f[4]);
                        e.ext       = ext_kind_e'(f[5][2:0]);
                        e.src.data  = xword_t'(f[6]);
                        m.valid     = f[7][0];
                        m.rd        = reg_addr_t'(f[8]);
                        m.data      = xword_t'(f[9]);
                        w.valid     = f[10][0];
                        w.rd        = reg_addr_t'(f[11]);
                        w.data      = xword_t'(f[12]);
                        x.valid     = f[0][0];  // pulse follows the strobe
                        x.op1       = xword_t'(f[13]);
                        x.op2       = xword_t'(f[14]);
                        req_q.push_back(r);
                        ex_q.push_back(e);
                        mem_q.push_back(m);
                        wb_q.push_back(w);
                        exp_q.push_back(x);
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (num_vectors * 4 + 100) @(posedge clk);
        abort_run("watchdog timeout, the vectors did not finish in time");
    end

    // a bound assertion failing ends the run as well
    initial begin : assertion_watch
        wait (operand_read_top_i.operand_read_properties_i.fail_count != 0);
        abort_run("a concurrent assertion on the DUT failed");
    end

    initial begin : main
        req            = '0;
        ex_fwd         = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        rst_n          = 1'b0;
        vectors_loaded = 1'b0;
        load_patterns(num_vectors);
        if (num_vectors < 0) begin
            abort_run("could not open testbench/operand_patterns.txt");
        end else if (num_vectors == 0) begin
            abort_run("the pattern file holds no vectors");
        end else begin
            vectors_loaded = 1'b1;
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            for (int i = 0; i <= num_vectors; i++) begin
                @(posedge clk);
                if (i < num_vectors) begin
                    req     <= req_q[i];
                    ex_fwd  <= ex_q[i];
                    mem_fwd <= mem_q[i];
                    wb_fwd  <= wb_q[i];
                end else begin
                    req     <= '0;  // drain the last vector
                    ex_fwd  <= '0;
                    mem_fwd <= '0;
                    wb_fwd  <= '0;
                end
                if (i > 0) begin
                    @(negedge clk);  // result of the previous vector
                    check_valid(operands, exp_q[i-1], i - 1);
                    check_operands(operands, exp_q[i-1], i - 1);
                end
            end
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
